//--- rtl/mam_defines.svh
// Memory access bridge constants
`ifndef MAM_DEFINES_SVH
`define MAM_DEFINES_SVH

// Memory port widths
`define MAM_DATA_WIDTH 32
`define MAM_ADDR_WIDTH 32

// Debug interconnect flit payload
`define MAM_FLIT_WIDTH 16

// Flits per memory word and per address, upper half first
`define MAM_WORD_FLITS (`MAM_DATA_WIDTH / `MAM_FLIT_WIDTH)
`define MAM_ADDR_FLITS (`MAM_ADDR_WIDTH / `MAM_FLIT_WIDTH)

// Every packet opens with this many header flits
`define MAM_HDR_FLITS 2

// Longest response packet, header included
`define MAM_MAX_PKT_LEN 8

// Type marker above the id in the second response header flit
`define MAM_RESP_TYPE 6'b011111

// Burst length field of the command flit
`define MAM_BEATS_WIDTH 13

`endif

//--- rtl/mam_pkg.sv
// Memory access bridge types
`include "mam_defines.svh"

package mam_pkg;

   // One flit on the debug interconnect
   typedef struct packed {
      logic                       valid;
      logic                       last;
      logic [`MAM_FLIT_WIDTH-1:0] data;
   } mam_flit_t;

   // Command flit, read as a burst or as a single beat with byte strobe
   typedef union packed {
      struct packed {
         logic                        rw;     // 1 write, 0 read
         logic                        burst;
         logic                        sync;
         logic [`MAM_BEATS_WIDTH-1:0] beats;
      } burst_view;
      struct packed {
         logic                        rw;
         logic                        burst;
         logic                        sync;
         logic [`MAM_FLIT_WIDTH-4-`MAM_DATA_WIDTH/8:0] unused;
         logic [`MAM_DATA_WIDTH/8-1:0] strb;
      } single_view;
   } mam_cmd_u;

   // Request to the memory port
   typedef struct packed {
      logic                        rw;
      logic                        burst;
      logic                        sync;
      logic [`MAM_ADDR_WIDTH-1:0]  addr;
      logic [`MAM_BEATS_WIDTH-1:0] beats;
   } mam_req_t;

   // Handed from the decoder to the data units
   typedef struct packed {
      logic [`MAM_BEATS_WIDTH-1:0]  beats;
      logic                         sync;
      logic [`MAM_DATA_WIDTH/8-1:0] strb;
      logic                         hdr_pending; // Data starts after a new header
   } mam_job_t;

endpackage

//--- rtl/mam_ctrl.sv
// Command and address decoder
`include "mam_defines.svh"

module mam_ctrl (
   input  logic               clk,
   input  logic               rst,
   input  mam_pkg::mam_flit_t debug_in,
   output logic               debug_in_ready,
   input  logic               wr_done,
   input  logic               resp_done,
   output mam_pkg::mam_req_t  req,
   output logic               req_valid,
   input  logic               req_ready,
   output logic               wr_start,
   output logic               rd_start,
   output mam_pkg::mam_job_t  job
);
   import mam_pkg::*;

   localparam int CNT_W = $clog2(`MAM_HDR_FLITS > `MAM_ADDR_FLITS ?
                                 `MAM_HDR_FLITS : `MAM_ADDR_FLITS);
   localparam logic [CNT_W-1:0] HDR_LAST  = CNT_W'(`MAM_HDR_FLITS - 1);
   localparam logic [CNT_W-1:0] ADDR_LAST = CNT_W'(`MAM_ADDR_FLITS - 1);
   localparam logic [`MAM_BEATS_WIDTH-1:0] ONE_BEAT = 1;

   typedef enum logic [2:0] {C_HDR, C_CMD, C_ADDR, C_REQ, C_BUSY} cstate_t;

   cstate_t                      state;
   logic [CNT_W-1:0]             cnt;      // Header or address flit index
   mam_cmd_u                     cmd;
   mam_req_t                     req_q;
   logic [`MAM_DATA_WIDTH/8-1:0] strb_q;
   logic                         last_q;   // Address flit closed its packet
   logic                         flit_in;

   assign cmd     = debug_in.data;
   assign flit_in = debug_in.valid && debug_in_ready;

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= C_HDR;
         cnt   <= '0;
      end else begin
         case (state)
            C_HDR: begin
               if (flit_in) begin
                  if (cnt == HDR_LAST) begin
                     cnt   <= '0;
                     state <= C_CMD;
                  end else begin
                     cnt <= cnt + 1'b1;
                  end
               end
            end
            C_CMD: begin
               if (flit_in) begin
                  state <= C_ADDR;
               end
            end
            C_ADDR: begin
               if (flit_in) begin
                  if (cnt == ADDR_LAST) begin
                     cnt   <= '0;
                     state <= C_REQ;
                  end else begin
                     cnt <= cnt + 1'b1;
                  end
               end
            end
            C_REQ: begin
               if (req_ready) begin
                  state <= C_BUSY;   // Job goes to a data unit now
               end
            end
            C_BUSY: begin
               if (wr_done || resp_done) begin
                  state <= C_HDR;
               end
            end
            default: state <= C_HDR;
         endcase
      end
   end

   // Decoded command and address
   always_ff @(posedge clk) begin
      if (state == C_CMD && flit_in) begin
         req_q.rw    <= cmd.burst_view.rw;
         req_q.burst <= cmd.burst_view.burst;
         req_q.sync  <= cmd.burst_view.sync;
         req_q.beats <= cmd.burst_view.burst ? cmd.burst_view.beats : ONE_BEAT;
         strb_q      <= cmd.burst_view.burst ? '1 : cmd.single_view.strb;
      end
      if (state == C_ADDR && flit_in) begin
         req_q.addr[(ADDR_LAST - cnt)*`MAM_FLIT_WIDTH +: `MAM_FLIT_WIDTH] <= debug_in.data;
         last_q <= debug_in.last;
      end
   end

   assign debug_in_ready = state == C_HDR || state == C_CMD || state == C_ADDR;
   assign req            = req_q;
   assign req_valid      = state == C_REQ;

   // One-cycle dispatch strobes on the request handshake
   assign wr_start = req_valid && req_ready && req_q.rw;
   assign rd_start = req_valid && req_ready && !req_q.rw;

   always_comb begin
      job.beats       = req_q.beats;
      job.sync        = req_q.sync;
      job.strb        = strb_q;
      job.hdr_pending = last_q;
   end

endmodule

//--- rtl/mam_write_unpack.sv
// Write data unpacker
`include "mam_defines.svh"

module mam_write_unpack (
   input  logic                         clk,
   input  logic                         rst,
   input  mam_pkg::mam_flit_t           debug_in,
   output logic                         debug_in_ready,
   input  logic                         wr_start,
   input  mam_pkg::mam_job_t            job,
   output logic [`MAM_DATA_WIDTH-1:0]   write_data,
   output logic [`MAM_DATA_WIDTH/8-1:0] write_strb,
   output logic                         write_valid,
   input  logic                         write_ready,
   input  logic                         write_complete,
   output logic                         wr_done,
   output logic                         ack_start
);
   localparam int FC_W = $clog2(`MAM_WORD_FLITS);
   localparam int HC_W = $clog2(`MAM_HDR_FLITS);
   localparam logic [FC_W-1:0] WORD_LAST = FC_W'(`MAM_WORD_FLITS - 1);
   localparam logic [HC_W-1:0] HDR_LAST  = HC_W'(`MAM_HDR_FLITS - 1);
   localparam logic [`MAM_BEATS_WIDTH-1:0] ONE_BEAT = 1;

   typedef enum logic [2:0] {W_IDLE, W_HDR, W_DATA, W_WAIT, W_SYNC} wstate_t;

   wstate_t                      state;
   logic [FC_W-1:0]              fcnt;        // Flit position in the word
   logic [HC_W-1:0]              hcnt;
   logic [`MAM_BEATS_WIDTH-1:0]  beats_q;
   logic                         sync_q;
   logic [`MAM_DATA_WIDTH/8-1:0] strb_q;
   logic                         in_pkt_q;    // Stalled word left mid-packet
   logic                         comp_seen_q;
   logic [`MAM_DATA_WIDTH-1:0]   word_q;
   logic [`MAM_DATA_WIDTH-1:0]   word_nxt;
   logic                         word_end;
   logic                         xfer;
   logic                         last_xfer;

   // Current flit merged into the word, upper half first
   always_comb begin
      word_nxt = word_q;
      word_nxt[(WORD_LAST - fcnt)*`MAM_FLIT_WIDTH +: `MAM_FLIT_WIDTH] = debug_in.data;
   end

   assign word_end       = state == W_DATA && debug_in.valid && fcnt == WORD_LAST;
   assign debug_in_ready = state == W_HDR || state == W_DATA;
   assign write_valid    = word_end || state == W_WAIT;
   assign write_data     = (state == W_WAIT) ? word_q : word_nxt;
   assign write_strb     = strb_q;
   assign xfer           = write_valid && write_ready;
   assign last_xfer      = xfer && beats_q == ONE_BEAT;

   always_ff @(posedge clk) begin
      if (rst) begin
         state       <= W_IDLE;
         fcnt        <= '0;
         hcnt        <= '0;
         comp_seen_q <= 1'b0;
         wr_done     <= 1'b0;
         ack_start   <= 1'b0;
      end else begin
         wr_done   <= last_xfer && !sync_q;
         ack_start <= 1'b0;
         if (write_complete) begin
            comp_seen_q <= 1'b1;
         end
         case (state)
            W_IDLE: begin
               if (wr_start) begin
                  state       <= job.hdr_pending ? W_HDR : W_DATA;
                  fcnt        <= '0;
                  hcnt        <= '0;
                  comp_seen_q <= 1'b0;
               end
            end
            W_HDR: begin
               if (debug_in.valid) begin
                  hcnt <= hcnt + 1'b1;
                  if (hcnt == HDR_LAST) begin
                     hcnt  <= '0;
                     state <= W_DATA;
                  end
               end
            end
            W_DATA: begin
               if (debug_in.valid) begin
                  fcnt <= (fcnt == WORD_LAST) ? '0 : fcnt + 1'b1;
                  if (word_end && !write_ready) begin
                     state <= W_WAIT;
                  end else if (debug_in.last) begin
                     state <= W_HDR;   // Word continues in the next packet
                  end
               end
            end
            W_WAIT: begin
               if (write_ready) begin
                  state <= in_pkt_q ? W_DATA : W_HDR;
               end
            end
            W_SYNC: begin
               if (write_complete) begin
                  state     <= W_IDLE;
                  ack_start <= 1'b1;
               end
            end
            default: state <= W_IDLE;
         endcase
         // Final beat overrides any packet bookkeeping
         if (last_xfer) begin
            if (!sync_q) begin
               state <= W_IDLE;
            end else if (comp_seen_q || write_complete) begin
               state     <= W_IDLE;
               ack_start <= 1'b1;
            end else begin
               state <= W_SYNC;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (wr_start) begin
         beats_q <= job.beats;
         sync_q  <= job.sync;
         strb_q  <= job.strb;
      end else if (xfer) begin
         beats_q <= beats_q - 1'b1;
      end
      if (state == W_DATA && debug_in.valid) begin
         word_q <= word_nxt;
      end
      if (word_end && !write_ready) begin
         in_pkt_q <= !debug_in.last;
      end
   end

endmodule

//--- rtl/mam_resp_packer.sv
// Response packet builder
`include "mam_defines.svh"

module mam_resp_packer (
   input  logic                       clk,
   input  logic                       rst,
   input  logic [15:0]                id,
   input  logic                       rd_start,
   input  logic                       ack_start,
   input  mam_pkg::mam_job_t          job,
   input  logic [`MAM_DATA_WIDTH-1:0] read_data,
   input  logic                       read_valid,
   output logic                       read_ready,
   output mam_pkg::mam_flit_t         debug_out,
   input  logic                       debug_out_ready,
   output logic                       resp_done
);
   localparam int PC_W = $clog2(`MAM_MAX_PKT_LEN);
   localparam int FC_W = $clog2(`MAM_WORD_FLITS);
   localparam int ID_W = `MAM_FLIT_WIDTH - $bits(`MAM_RESP_TYPE);
   localparam logic [PC_W-1:0] PKT_LAST  = PC_W'(`MAM_MAX_PKT_LEN - 1);
   localparam logic [PC_W-1:0] HDR_LAST  = PC_W'(`MAM_HDR_FLITS - 1);
   localparam logic [FC_W-1:0] WORD_LAST = FC_W'(`MAM_WORD_FLITS - 1);
   localparam logic [`MAM_BEATS_WIDTH-1:0] ONE_BEAT = 1;

   typedef enum logic [1:0] {R_IDLE, R_HDR, R_DATA} rstate_t;

   rstate_t                     state;
   logic [PC_W-1:0]             pcnt;      // Flit index in the packet
   logic [FC_W-1:0]             fcnt;      // Flit index in the word
   logic [`MAM_BEATS_WIDTH-1:0] beats_q;
   logic                        ack_q;     // Two-flit acknowledge only
   logic                        flit_out;
   logic                        word_out;
   logic                        final_flit;

   assign final_flit = fcnt == WORD_LAST && beats_q == ONE_BEAT;

   always_comb begin
      debug_out = '0;
      case (state)
         R_HDR: begin
            debug_out.valid = 1'b1;
            if (pcnt == HDR_LAST) begin
               debug_out.data = {`MAM_RESP_TYPE, id[ID_W-1:0]};
               debug_out.last = ack_q;
            end
         end
         R_DATA: begin
            debug_out.valid = read_valid;
            debug_out.data  = read_data[(WORD_LAST - fcnt)*`MAM_FLIT_WIDTH +: `MAM_FLIT_WIDTH];
            debug_out.last  = pcnt == PKT_LAST || final_flit;
         end
         default: ;
      endcase
   end

   assign flit_out   = debug_out.valid && debug_out_ready;
   assign word_out   = state == R_DATA && flit_out && fcnt == WORD_LAST;
   assign read_ready = word_out;   // Word retired with its last flit

   always_ff @(posedge clk) begin
      if (rst) begin
         state     <= R_IDLE;
         pcnt      <= '0;
         fcnt      <= '0;
         resp_done <= 1'b0;
      end else begin
         resp_done <= 1'b0;
         case (state)
            R_IDLE: begin
               pcnt <= '0;
               fcnt <= '0;
               if (rd_start || ack_start) begin
                  state <= R_HDR;
               end
            end
            R_HDR: begin
               if (flit_out) begin
                  pcnt <= pcnt + 1'b1;
                  if (pcnt == HDR_LAST && ack_q) begin
                     state     <= R_IDLE;
                     resp_done <= 1'b1;
                  end else if (pcnt == HDR_LAST) begin
                     state <= R_DATA;
                  end
               end
            end
            R_DATA: begin
               if (flit_out) begin
                  fcnt <= (fcnt == WORD_LAST) ? '0 : fcnt + 1'b1;
                  pcnt <= pcnt + 1'b1;
                  if (final_flit) begin
                     state     <= R_IDLE;
                     resp_done <= 1'b1;
                  end else if (pcnt == PKT_LAST) begin
                     state <= R_HDR;   // Packet full, more beats follow
                     pcnt  <= '0;
                  end
               end
            end
            default: state <= R_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == R_IDLE && (rd_start || ack_start)) begin
         ack_q   <= ack_start;
         beats_q <= job.beats;
      end else if (word_out) begin
         beats_q <= beats_q - 1'b1;
      end
   end

endmodule

//--- rtl/mam_top.sv
// Memory access bridge top
`include "mam_defines.svh"

module mam_top (
   input  logic                         clk,
   input  logic                         rst,
   input  logic [15:0]                  id,

   input  mam_pkg::mam_flit_t           debug_in,
   output logic                         debug_in_ready,
   output mam_pkg::mam_flit_t           debug_out,
   input  logic                         debug_out_ready,

   output mam_pkg::mam_req_t            req,
   output logic                         req_valid,
   input  logic                         req_ready,

   output logic [`MAM_DATA_WIDTH-1:0]   write_data,
   output logic [`MAM_DATA_WIDTH/8-1:0] write_strb,
   output logic                         write_valid,
   input  logic                         write_ready,
   input  logic                         write_complete,

   input  logic [`MAM_DATA_WIDTH-1:0]   read_data,
   input  logic                         read_valid,
   output logic                         read_ready
);
   import mam_pkg::*;

   mam_job_t job;
   logic     wr_start;
   logic     rd_start;
   logic     wr_done;
   logic     ack_start;
   logic     resp_done;
   logic     ctrl_in_ready;
   logic     wu_in_ready;

   // Only one of the two is active at a time
   assign debug_in_ready = ctrl_in_ready | wu_in_ready;

   mam_ctrl u_ctrl (
      .clk            (clk),
      .rst            (rst),
      .debug_in       (debug_in),
      .debug_in_ready (ctrl_in_ready),
      .wr_done        (wr_done),
      .resp_done      (resp_done),
      .req            (req),
      .req_valid      (req_valid),
      .req_ready      (req_ready),
      .wr_start       (wr_start),
      .rd_start       (rd_start),
      .job            (job)
   );

   mam_write_unpack u_write (
      .clk            (clk),
      .rst            (rst),
      .debug_in       (debug_in),
      .debug_in_ready (wu_in_ready),
      .wr_start       (wr_start),
      .job            (job),
      .write_data     (write_data),
      .write_strb     (write_strb),
      .write_valid    (write_valid),
      .write_ready    (write_ready),
      .write_complete (write_complete),
      .wr_done        (wr_done),
      .ack_start      (ack_start)
   );

   mam_resp_packer u_resp (
      .clk             (clk),
      .rst             (rst),
      .id              (id),
      .rd_start        (rd_start),
      .ack_start       (ack_start),
      .job             (job),
      .read_data       (read_data),
      .read_valid      (read_valid),
      .read_ready      (read_ready),
      .debug_out       (debug_out),
      .debug_out_ready (debug_out_ready),
      .resp_done       (resp_done)
   );

endmodule

//--- dv/mam_tb_sva.sv
// Bridge handshake assertions
`include "mam_defines.svh"

module mam_tb_sva (
   input logic                         clk,
   input logic                         rst,
   input mam_pkg::mam_req_t            req,
   input logic                         req_valid,
   input logic                         req_ready,
   input logic [`MAM_DATA_WIDTH-1:0]   write_data,
   input logic [`MAM_DATA_WIDTH/8-1:0] write_strb,
   input logic                         write_valid,
   input logic                         write_ready,
   input mam_pkg::mam_flit_t           debug_out,
   input logic                         debug_out_ready,
   input logic                         read_valid,
   input logic                         read_ready
);
   timeunit 1ns;
   timeprecision 100ps;

   int unsigned fail_count = 0;

   req_hold: assert property (@(posedge clk) disable iff (rst)
      req_valid && !req_ready |=> req_valid && $stable(req))
      else begin $error("req dropped or changed before req_ready"); fail_count++; end

   write_hold: assert property (@(posedge clk) disable iff (rst)
      write_valid && !write_ready |=>
         write_valid && $stable(write_data) && $stable(write_strb))
      else begin $error("write beat dropped or changed before write_ready"); fail_count++; end

   out_hold: assert property (@(posedge clk) disable iff (rst)
      debug_out.valid && !debug_out_ready |=> debug_out.valid && $stable(debug_out))
      else begin $error("debug_out flit dropped or changed while stalled"); fail_count++; end

   // Idle outputs right after reset
   reset_idle: assert property (@(posedge clk) rst |=> !req_valid && !write_valid)
      else begin $error("req_valid or write_valid high after reset"); fail_count++; end

   read_ready_valid: assert property (@(posedge clk) disable iff (rst)
      read_ready |-> read_valid)
      else begin $error("read_ready high without read_valid"); fail_count++; end

endmodule

bind mam_top mam_tb_sva u_sva (
   .clk             (clk),
   .rst             (rst),
   .req             (req),
   .req_valid       (req_valid),
   .req_ready       (req_ready),
   .write_data      (write_data),
   .write_strb      (write_strb),
   .write_valid     (write_valid),
   .write_ready     (write_ready),
   .debug_out       (debug_out),
   .debug_out_ready (debug_out_ready),
   .read_valid      (read_valid),
   .read_ready      (read_ready)
);

//--- dv/mam_tb.sv
// Memory access bridge testbench
`include "mam_defines.svh"

module mam_tb;
   timeunit 1ns;
   timeprecision 100ps;
   import mam_pkg::*;

   localparam int TIMEOUT = 2000;
   localparam logic [15:0] ID = 16'hC3A7;
   localparam logic [15:0] RESP_HDR = {`MAM_RESP_TYPE, ID[9:0]};   // Type above truncated id
   localparam int PAYLOAD_MAX = `MAM_MAX_PKT_LEN - `MAM_HDR_FLITS;

   logic                         clk;
   logic                         rst;
   mam_flit_t                    debug_in;
   logic                         debug_in_ready;
   mam_flit_t                    debug_out;
   logic                         debug_out_ready;
   mam_req_t                     req;
   logic                         req_valid;
   logic                         req_ready;
   logic [`MAM_DATA_WIDTH-1:0]   write_data;
   logic [`MAM_DATA_WIDTH/8-1:0] write_strb;
   logic                         write_valid;
   logic                         write_ready;
   logic                         write_complete;
   logic [`MAM_DATA_WIDTH-1:0]   read_data;
   logic                         read_valid;
   logic                         read_ready;

   int   seed = 92;
   logic bp = 1'b0;                                   // Random back-pressure on
   logic [`MAM_DATA_WIDTH-1:0]   mem [logic [`MAM_ADDR_WIDTH-1:0]];
   mam_req_t                     req_log[$];
   logic [`MAM_DATA_WIDTH-1:0]   wdata_log[$];
   logic [`MAM_DATA_WIDTH/8-1:0] wstrb_log[$];
   logic [`MAM_FLIT_WIDTH-1:0]   out_data[$];
   logic                         out_last[$];
   int   comp_count = 0;
   int   comps_at_ack = 0;
   int   wr_left = 0;
   int   rd_left = 0;
   int   comp_wait = 0;
   logic wr_sync = 1'b0;
   logic rd_taken;
   logic [`MAM_ADDR_WIDTH-1:0]   wr_addr;
   logic [`MAM_ADDR_WIDTH-1:0]   rd_addr;

   mam_top UUT (.id(ID), .*);

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // Untouched locations read back an address-derived pattern
   function automatic logic [31:0] mem_word(input logic [31:0] addr);
      if (mem.exists(addr)) begin
         return mem[addr];
      end
      return addr ^ {addr[15:0], addr[31:16]} ^ 32'h5A5A_C3C3;
   endfunction

   // Memory model and debug_out monitor
   initial begin
      req_ready       = 1'b0;
      write_ready     = 1'b0;
      write_complete  = 1'b0;
      read_valid      = 1'b0;
      read_data       = '0;
      debug_out_ready = 1'b0;
      forever begin
         @(posedge clk);
         rd_taken = 1'b0;
         if (!rst) begin
            if (req_valid && req_ready) begin
               req_log.push_back(req);
               if (req.rw) begin
                  wr_addr = req.addr;
                  wr_left = int'(req.beats);
                  wr_sync = req.sync;
               end else begin
                  rd_addr = req.addr;
                  rd_left = int'(req.beats);
               end
            end
            if (write_valid && write_ready) begin
               mem[wr_addr] = write_data;
               wdata_log.push_back(write_data);
               wstrb_log.push_back(write_strb);
               wr_addr = wr_addr + 4;
               wr_left--;
               if (wr_left == 0 && wr_sync) begin
                  comp_wait = 3 + int'({$random(seed)} % 4);
               end
            end
            if (read_valid && read_ready) begin
               rd_addr  = rd_addr + 4;
               rd_left--;
               rd_taken = 1'b1;
            end
            if (debug_out.valid && debug_out_ready) begin
               if (out_data.size() == 0) begin
                  comps_at_ack = comp_count;   // Completions seen before the first flit
               end
               out_data.push_back(debug_out.data);
               out_last.push_back(debug_out.last);
            end
         end
         #5;
         req_ready       = ({$random(seed)} % 3) != 0;
         write_ready     = bp ? ({$random(seed)} % 2) != 0 : 1'b1;
         debug_out_ready = bp ? ({$random(seed)} % 2) != 0 : 1'b1;
         write_complete  = 1'b0;
         if (comp_wait > 0) begin
            comp_wait--;
            if (comp_wait == 0) begin
               write_complete = 1'b1;
               comp_count++;
            end
         end
         if (rd_left == 0) begin
            read_valid = 1'b0;
         end else if (!read_valid || rd_taken) begin   // Hold a word until taken
            read_valid = ({$random(seed)} % 4) != 0;
            read_data  = mem_word(rd_addr);
         end
      end
   end

   task automatic fail_run(input string what);
      $display("%s", what);
      $display("SOME TESTS FAILED");
      $fatal(1, "Run stopped");
   endtask

   task automatic check(input string test, input logic [63:0] exp, input logic [63:0] act);
      if (exp !== act) begin
         $display("Error: %s expected %0h actual %0h", test, exp, act);
         $display("SOME TESTS FAILED");
         $fatal(1, "Value mismatch");
      end
   endtask

   task automatic send_flit(input logic [15:0] data, input logic last);
      int n;
      n = 0;
      debug_in.valid = 1'b1;
      debug_in.last  = last;
      debug_in.data  = data;
      do begin
         @(posedge clk);
         n++;
         if (n > TIMEOUT) fail_run("The bridge never accepted a debug_in flit");
      end while (!debug_in_ready);
      #5;
      debug_in.valid = 1'b0;
   endtask

   task automatic send_header();
      send_flit(16'h0001, 1'b0);
      send_flit(ID, 1'b0);
   endtask

   function automatic logic [15:0] make_cmd(input logic rw, input logic burst,
                                            input logic sync, input logic [12:0] field);
      return {rw, burst, sync, field};
   endfunction

   // Header, command and address; last on the address ends the packet
   task automatic send_request(input logic [15:0] cmd, input logic [31:0] addr,
                               input logic addr_last);
      send_header();
      send_flit(cmd, 1'b0);
      send_flit(addr[31:16], 1'b0);
      send_flit(addr[15:0], addr_last);
   endtask

   task automatic wait_writes(input int n);
      int t;
      t = 0;
      while (wdata_log.size() < n) begin
         @(posedge clk);
         #5;
         t++;
         if (t > TIMEOUT) fail_run("The memory never received all write beats");
      end
   endtask

   task automatic wait_flits(input int n);
      int t;
      t = 0;
      while (out_data.size() < n) begin
         @(posedge clk);
         #5;
         t++;
         if (t > TIMEOUT) fail_run("Response flits never arrived on debug_out");
      end
   endtask

   task automatic settle(input int n);
      repeat (n) @(posedge clk);
      #5;
   endtask

   task automatic clear_logs();
      req_log.delete();
      wdata_log.delete();
      wstrb_log.delete();
      out_data.delete();
      out_last.delete();
      comp_count = 0;
      comps_at_ack = 0;
   endtask

   task automatic test_single_write();
      clear_logs();
      send_request(make_cmd(1'b1, 1'b0, 1'b0, {9'b0, 4'b0110}), 32'h0000_1040, 1'b0);
      send_flit(16'hBEEF, 1'b0);
      send_flit(16'h1234, 1'b1);
      wait_writes(1);
      settle(20);                                       // Nothing may follow on debug_out
      check("single_write requests", 1, req_log.size());
      check("single_write rw", 1, req_log[0].rw);
      check("single_write burst", 0, req_log[0].burst);
      check("single_write sync", 0, req_log[0].sync);
      check("single_write beats", 1, req_log[0].beats);
      check("single_write addr", 32'h0000_1040, req_log[0].addr);
      check("single_write data", 32'hBEEF_1234, wdata_log[0]);
      check("single_write strb", 4'b0110, wstrb_log[0]);
      check("single_write response flits", 0, out_data.size());
   endtask

   // Five words over three data packets, one word split between packets
   task automatic test_burst_write(input string name, input logic [31:0] addr);
      logic [31:0] w[5];
      logic [15:0] flits[10];
      int          pkt_len[3] = '{4, 3, 3};
      int          f;
      foreach (w[i]) begin
         w[i] = $random(seed);
         flits[2*i]   = w[i][31:16];
         flits[2*i+1] = w[i][15:0];
      end
      clear_logs();
      send_request(make_cmd(1'b1, 1'b1, 1'b0, 13'd5), addr, 1'b1);
      f = 0;
      for (int p = 0; p < 3; p++) begin
         send_header();
         for (int k = 0; k < pkt_len[p]; k++) begin
            send_flit(flits[f], k == pkt_len[p] - 1);
            f++;
         end
      end
      wait_writes(5);
      check({name, " requests"}, 1, req_log.size());
      check({name, " rw"}, 1, req_log[0].rw);
      check({name, " burst"}, 1, req_log[0].burst);
      check({name, " beats"}, 5, req_log[0].beats);
      check({name, " addr"}, addr, req_log[0].addr);
      foreach (w[i]) begin
         check({name, " data"}, w[i], wdata_log[i]);
         check({name, " strb"}, 4'hF, wstrb_log[i]);
      end
   endtask

   task automatic test_burst_read(input string name, input logic [31:0] addr);
      logic [31:0] w[6];
      logic [15:0] exp_data[$];
      logic        exp_last[$];
      int          rem;
      int          n;
      int          idx;
      foreach (w[i]) begin
         w[i] = $random(seed);
         mem[addr + 4*i] = w[i];
      end
      // Expected packets: two header flits, then at most PAYLOAD_MAX payload flits
      rem = 6 * `MAM_WORD_FLITS;
      idx = 0;
      while (rem > 0) begin
         n = (rem > PAYLOAD_MAX) ? PAYLOAD_MAX : rem;
         exp_data.push_back(16'h0000);
         exp_last.push_back(1'b0);
         exp_data.push_back(RESP_HDR);
         exp_last.push_back(1'b0);
         for (int k = 0; k < n; k++) begin
            exp_data.push_back(idx % 2 == 0 ? w[idx/2][31:16] : w[idx/2][15:0]);
            exp_last.push_back(k == n - 1);
            idx++;
         end
         rem -= n;
      end
      clear_logs();
      send_request(make_cmd(1'b0, 1'b1, 1'b0, 13'd6), addr, 1'b1);
      wait_flits(exp_data.size());
      settle(10);
      check({name, " rw"}, 0, req_log[0].rw);
      check({name, " beats"}, 6, req_log[0].beats);
      check({name, " addr"}, addr, req_log[0].addr);
      check({name, " flit count"}, exp_data.size(), out_data.size());
      foreach (exp_data[i]) begin
         check({name, " flit data"}, exp_data[i], out_data[i]);
         check({name, " flit last"}, exp_last[i], out_last[i]);
      end
   endtask

   task automatic test_sync_write(input string name, input logic burst, input int beats);
      logic [15:0] cmd;
      logic [31:0] w;
      cmd = burst ? make_cmd(1'b1, 1'b1, 1'b1, 13'(beats))
                  : make_cmd(1'b1, 1'b0, 1'b1, {9'b0, 4'hF});
      clear_logs();
      send_request(cmd, 32'h0000_3000, 1'b0);
      for (int i = 0; i < beats; i++) begin
         w = $random(seed);
         send_flit(w[31:16], 1'b0);
         send_flit(w[15:0], i == beats - 1);
      end
      wait_flits(2);
      settle(20);
      check({name, " sync"}, 1, req_log[0].sync);
      check({name, " write beats"}, beats, wdata_log.size());
      check({name, " completion before ack"}, 1, comps_at_ack);
      check({name, " ack flits"}, 2, out_data.size());
      check({name, " ack flit 0"}, 16'h0000, out_data[0]);
      check({name, " ack last 0"}, 0, out_last[0]);
      check({name, " ack flit 1"}, RESP_HDR, out_data[1]);
      check({name, " ack last 1"}, 1, out_last[1]);
   endtask

   initial begin
      debug_in = '0;
      rst      = 1'b1;
      repeat (10) @(posedge clk);
      #5;
      rst = 1'b0;
      test_single_write();
      test_burst_write("burst_write", 32'h0000_2000);
      test_burst_read("burst_read", 32'h0000_2400);
      test_sync_write("sync_single", 1'b0, 1);
      test_sync_write("sync_burst", 1'b1, 3);
      bp = 1'b1;
      test_burst_write("burst_write_bp", 32'h0000_5000);
      test_burst_read("burst_read_bp", 32'h0000_5400);
      if (UUT.u_sva.fail_count != 0) begin
         fail_run("Handshake assertions failed during the run");
      end else begin
         $display("ALL TESTS PASSED");
         $finish;
      end
   end

endmodule

//--- flist.f
+incdir+rtl
rtl/mam_pkg.sv
rtl/mam_ctrl.sv
rtl/mam_write_unpack.sv
rtl/mam_resp_packer.sv
rtl/mam_top.sv
dv/mam_tb_sva.sv
dv/mam_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       ?= mam_tb
FLIST     ?= flist.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
